/* Makefile */
.PHONY: all compile run clean

all: run

compile: obj_dir/Vtb_mera_bus

obj_dir/Vtb_mera_bus: files.f *.sv
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_mera_bus -f files.f --Mdir obj_dir

run: compile
	./obj_dir/Vtb_mera_bus | tee sim.log
	@if grep -q "Test failed" sim.log; then \
		echo "simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "Test completed successfully" sim.log; then \
		echo "simulation ended without a pass line"; exit 1; \
	fi
	@echo "simulation PASSED"

clean:
	rm -rf obj_dir sim.log

/* bus_channel.sv */
module bus_channel (
	input  logic               clk_sys,
	input  logic               rst_n,
	// master request side
	input  logic               req_valid,
	output logic               req_ready,
	input  mera_pkg::bus_req_t req,
	// master answer side
	output logic               rsp_valid,
	input  logic               rsp_ready,
	output mera_pkg::bus_rsp_t rsp,
	// toward the reservation switch
	output logic               bus_rq,
	output mera_pkg::bus_req_t cur_req,
	input  logic               grant,
	input  logic               done,
	input  mera_pkg::mem_rsp_t mem_ans
);

	typedef enum logic [1:0] {
		idle,
		wait_grant,
		wait_answer,
		hold_rsp
	} chan_state_e;

	chan_state_e state;

	// latched request and built answer
	mera_pkg::bus_req_t req_q;
	mera_pkg::bus_rsp_t rsp_q;

	// cycles since grant
	logic [mera_pkg::TMO_W-1:0] tmo_cnt;

	// --------------------------------------
	// control
	// --------------------------------------

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state   <= idle;
			tmo_cnt <= '0;
		end else begin
			case (state)
				idle: begin
					// one item in flight at most
					if (req_valid) begin
						state <= wait_grant;
					end
				end
				wait_grant: begin
					// grant cycle counts as cycle 0
					if (grant) begin
						tmo_cnt <= 1;
						state   <= wait_answer;
					end
				end
				wait_answer: begin
					if (done && mem_ans.ok) begin
						state <= hold_rsp;
					end else if (tmo_cnt == mera_pkg::TMO_LAST) begin
						// nobody answered, report bus alarm
						state <= hold_rsp;
					end else begin
						tmo_cnt <= tmo_cnt + 1'b1;
					end
				end
				hold_rsp: begin
					// back-pressure keeps us here
					if (rsp_ready) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// --------------------------------------
	// payload
	// --------------------------------------

	always_ff @(posedge clk_sys) begin
		if (state == idle && req_valid) begin
			req_q <= req;
		end
		if (state == wait_answer) begin
			if (done && mem_ans.ok) begin
				rsp_q.status <= mera_pkg::st_ok;
				rsp_q.dt     <= mem_ans.dt;
			end else if (tmo_cnt == mera_pkg::TMO_LAST) begin
				rsp_q.status <= mera_pkg::st_alarm;
				rsp_q.dt     <= '0;
			end
		end
	end

	assign req_ready = (state == idle);
	assign rsp_valid = (state == hold_rsp);
	assign rsp       = rsp_q;

	// bus request held from the cycle after acceptance until the answer
	assign bus_rq  = (state == wait_grant) || (state == wait_answer);
	assign cur_req = req_q;

endmodule

/* bus_switch.sv */
module bus_switch (
	input  logic               clk_sys,
	input  logic               rst_n,
	// channel requests
	input  logic               rq_cpu,
	input  logic               rq_io,
	input  mera_pkg::bus_req_t req_cpu,
	input  mera_pkg::bus_req_t req_io,
	// reservation answers
	output logic               grant_cpu,
	output logic               grant_io,
	output logic               done_cpu,
	output logic               done_io,
	// toward memory
	output logic               mem_sel,
	output mera_pkg::bus_req_t mem_req,
	input  mera_pkg::mem_rsp_t ans,
	output mera_pkg::mem_rsp_t ans_out
);

	typedef enum logic {
		sw_free,
		sw_owned
	} sw_state_e;

	sw_state_e state;

	// current owner, 1 means io
	logic owner_io;
	// last channel served, for round-robin
	logic last_io;
	// first grant cycle marker
	logic first_q;

	logic pick_io;
	logic rq_owner;

	// --------------------------------------
	// arbitration
	// --------------------------------------

	// tie goes to the channel not served last
	always_comb begin
		if (rq_cpu && rq_io) begin
			pick_io = !last_io;
		end else begin
			pick_io = rq_io;
		end
	end

	assign rq_owner = owner_io ? rq_io : rq_cpu;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state    <= sw_free;
			owner_io <= 1'b0;
			last_io  <= 1'b1;
			first_q  <= 1'b0;
		end else begin
			first_q <= 1'b0;
			case (state)
				sw_free: begin
					if (rq_cpu || rq_io) begin
						state    <= sw_owned;
						owner_io <= pick_io;
						last_io  <= pick_io;
						first_q  <= 1'b1;
					end
				end
				sw_owned: begin
					// memory answered, or owner gave up after its timeout
					if (ans.ok || !rq_owner) begin
						state <= sw_free;
					end
				end
				default: state <= sw_free;
			endcase
		end
	end

	// --------------------------------------
	// routing
	// --------------------------------------

	assign grant_cpu = (state == sw_owned) && !owner_io;
	assign grant_io  = (state == sw_owned) && owner_io;

	// strobe only on the first cycle of a grant
	assign mem_sel = first_q;
	assign mem_req = owner_io ? req_io : req_cpu;

	// done reaches the owner only
	assign done_cpu = grant_cpu && ans.ok;
	assign done_io  = grant_io && ans.ok;
	assign ans_out  = ans;

endmodule

/* files.f */
mera_pkg.sv
bus_channel.sv
bus_switch.sv
mem_segments.sv
mera_bus.sv
mera_bus_props.sv
tb_mera_bus.sv

/* mem_segments.sv */
module mem_segments (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               sel,
	input  mera_pkg::bus_req_t req,
	output mera_pkg::mem_rsp_t ans
);

	// --------------------------------------
	// storage
	// --------------------------------------

	// present segments back to back
	logic [mera_pkg::DT_W-1:0] mem [mera_pkg::MEM_SEGMENTS * mera_pkg::MEM_SEG_WORDS];

	// --------------------------------------
	// request pipeline
	// --------------------------------------

	// stage valid bits, cleared on reset
	logic [mera_pkg::MEM_LATENCY-1:0] vld;
	// latched request per stage
	mera_pkg::bus_req_t pipe [mera_pkg::MEM_LATENCY];

	mera_pkg::bus_req_t last;
	logic                        present;
	logic                        hit;
	logic [mera_pkg::MEM_AW-1:0] idx;
	logic [mera_pkg::DT_W-1:0]   word;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vld <= '0;
		end else begin
			vld[0] <= sel;
			for (int i = 1; i < mera_pkg::MEM_LATENCY; i++) begin
				vld[i] <= vld[i-1];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		pipe[0] <= req;
		for (int i = 1; i < mera_pkg::MEM_LATENCY; i++) begin
			pipe[i] <= pipe[i-1];
		end
	end

	// --------------------------------------
	// last stage
	// --------------------------------------

	assign last = pipe[mera_pkg::MEM_LATENCY-1];

	// absent segment or address stays silent
	assign present = (last.nb < mera_pkg::NB_PRESENT) && (last.ad < mera_pkg::AD_PRESENT);
	assign hit     = vld[mera_pkg::MEM_LATENCY-1] && present;

	// segment picks the upper index bits
	assign idx  = {last.nb[mera_pkg::SEG_W-1:0], last.ad[mera_pkg::SEG_AW-1:0]};
	assign word = mem[idx];

	// write and set land at the end of the ok cycle
	always_ff @(posedge clk_sys) begin
		if (hit) begin
			case (last.cmd)
				mera_pkg::cmd_w: mem[idx] <= last.dt;
				mera_pkg::cmd_s: mem[idx] <= word | last.dt;
				default: begin
					// read leaves the word alone
				end
			endcase
		end
	end

	// old word for read and set, zero for write
	always_comb begin
		ans.ok = hit;
		if (hit && last.cmd != mera_pkg::cmd_w) begin
			ans.dt = word;
		end else begin
			ans.dt = '0;
		end
	end

endmodule

/* mera_bus.sv */
module mera_bus (
	input  logic               clk_sys,
	input  logic               rst_n,
	// cpu side
	input  logic               req_valid_cpu,
	output logic               req_ready_cpu,
	input  mera_pkg::bus_req_t req_cpu,
	output logic               rsp_valid_cpu,
	input  logic               rsp_ready_cpu,
	output mera_pkg::bus_rsp_t rsp_cpu,
	// i/o side
	input  logic               req_valid_io,
	output logic               req_ready_io,
	input  mera_pkg::bus_req_t req_io,
	output logic               rsp_valid_io,
	input  logic               rsp_ready_io,
	output mera_pkg::bus_rsp_t rsp_io
);

	// --------------------------------------
	// channel to switch
	// --------------------------------------

	logic               rq_cpu;
	logic               rq_io;
	mera_pkg::bus_req_t cur_cpu;
	mera_pkg::bus_req_t cur_io;
	logic               grant_cpu;
	logic               grant_io;
	logic               done_cpu;
	logic               done_io;
	// memory answer as seen by both channels
	mera_pkg::mem_rsp_t bus_ans;

	// switch to memory
	logic               mem_sel;
	mera_pkg::bus_req_t mem_req;
	mera_pkg::mem_rsp_t mem_ans;

	bus_channel u_cpu_chan (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.req_valid (req_valid_cpu),
		.req_ready (req_ready_cpu),
		.req       (req_cpu),
		.rsp_valid (rsp_valid_cpu),
		.rsp_ready (rsp_ready_cpu),
		.rsp       (rsp_cpu),
		.bus_rq    (rq_cpu),
		.cur_req   (cur_cpu),
		.grant     (grant_cpu),
		.done      (done_cpu),
		.mem_ans   (bus_ans)
	);

	bus_channel u_io_chan (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.req_valid (req_valid_io),
		.req_ready (req_ready_io),
		.req       (req_io),
		.rsp_valid (rsp_valid_io),
		.rsp_ready (rsp_ready_io),
		.rsp       (rsp_io),
		.bus_rq    (rq_io),
		.cur_req   (cur_io),
		.grant     (grant_io),
		.done      (done_io),
		.mem_ans   (bus_ans)
	);

	// --------------------------------------
	// reservation and memory
	// --------------------------------------

	bus_switch u_switch (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.rq_cpu    (rq_cpu),
		.rq_io     (rq_io),
		.req_cpu   (cur_cpu),
		.req_io    (cur_io),
		.grant_cpu (grant_cpu),
		.grant_io  (grant_io),
		.done_cpu  (done_cpu),
		.done_io   (done_io),
		.mem_sel   (mem_sel),
		.mem_req   (mem_req),
		.ans       (mem_ans),
		.ans_out   (bus_ans)
	);

	mem_segments u_mem (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sel     (mem_sel),
		.req     (mem_req),
		.ans     (mem_ans)
	);

endmodule

/* mera_bus_props.sv */
module mera_bus_props (
	input logic               clk_sys,
	input logic               rst_n,
	input logic               grant_cpu,
	input logic               grant_io,
	input logic               mem_sel,
	input logic               rsp_valid_cpu,
	input logic               rsp_ready_cpu,
	input mera_pkg::bus_rsp_t rsp_cpu,
	input logic               rsp_valid_io,
	input logic               rsp_ready_io,
	input mera_pkg::bus_rsp_t rsp_io
);
	timeunit 1ns;
	timeprecision 100ps;

	logic any_grant;

	assign any_grant = grant_cpu || grant_io;

	// ----------------------------------------
	// reservation switch
	// ----------------------------------------

	// one owner at a time
	a_grant_excl: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(grant_cpu && grant_io))
		else $error("grant_cpu and grant_io high together");

	// strobe only on the first grant cycle
	a_sel_first: assert property (@(posedge clk_sys) disable iff (!rst_n)
		mem_sel |-> any_grant && !$past(any_grant))
		else $error("mem_sel outside the first grant cycle");

	// ----------------------------------------
	// answer handshakes
	// ----------------------------------------

	a_rsp_hold_cpu: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rsp_valid_cpu && !rsp_ready_cpu |=> rsp_valid_cpu && $stable(rsp_cpu))
		else $error("cpu answer dropped or changed before rsp_ready");

	a_rsp_hold_io: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rsp_valid_io && !rsp_ready_io |=> rsp_valid_io && $stable(rsp_io))
		else $error("i/o answer dropped or changed before rsp_ready");

endmodule

// attached at the top where switch grants and channel answers meet
bind mera_bus mera_bus_props u_props (
	.clk_sys       (clk_sys),
	.rst_n         (rst_n),
	.grant_cpu     (grant_cpu),
	.grant_io      (grant_io),
	.mem_sel       (mem_sel),
	.rsp_valid_cpu (rsp_valid_cpu),
	.rsp_ready_cpu (rsp_ready_cpu),
	.rsp_cpu       (rsp_cpu),
	.rsp_valid_io  (rsp_valid_io),
	.rsp_ready_io  (rsp_ready_io),
	.rsp_io        (rsp_io)
);

/* mera_pkg.sv */
package mera_pkg;

	// --------------------------------------
	// sizes
	// --------------------------------------

	// field widths of a bus transfer
	localparam int NB_W = 4;
	localparam int AD_W = 16;
	localparam int DT_W = 16;

	// present memory: segments 0 and 1, 256 words each
	localparam int MEM_SEGMENTS = 2;
	localparam int MEM_SEG_WORDS = 256;

	// cycles from grant to bus alarm
	localparam int BUS_TIMEOUT = 16;

	// cycles from grant (mem_sel) to memory ok
	localparam int MEM_LATENCY = 2;

	// derived widths for the word array
	localparam int SEG_W = (MEM_SEGMENTS > 1) ? $clog2(MEM_SEGMENTS) : 1;
	localparam int SEG_AW = $clog2(MEM_SEG_WORDS);
	localparam int MEM_AW = SEG_W + SEG_AW;

	// timeout counter, must reach BUS_TIMEOUT
	localparam int TMO_W = $clog2(BUS_TIMEOUT + 1);
	localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(BUS_TIMEOUT);

	// first absent segment and first absent word address
	localparam logic [NB_W-1:0] NB_PRESENT = NB_W'(MEM_SEGMENTS);
	localparam logic [AD_W-1:0] AD_PRESENT = AD_W'(MEM_SEG_WORDS);

	// --------------------------------------
	// bus types
	// --------------------------------------

	// bus operation
	// set ORs dt into the word and returns the old word
	typedef enum logic [1:0] {
		cmd_r = 2'd0,
		cmd_w = 2'd1,
		cmd_s = 2'd2
	} bus_cmd_e;

	// answer kind seen by a master
	typedef enum logic {
		st_ok    = 1'b0,
		st_alarm = 1'b1
	} bus_status_e;

	// request from a master, 38 bits
	typedef struct packed {
		bus_cmd_e        cmd;
		logic [NB_W-1:0] nb;
		logic [AD_W-1:0] ad;
		logic [DT_W-1:0] dt;
	} bus_req_t;

	// answer to a master, 17 bits
	typedef struct packed {
		bus_status_e     status;
		logic [DT_W-1:0] dt;
	} bus_rsp_t;

	// memory answer on the bus, ok is a pulse
	typedef struct packed {
		logic            ok;
		logic [DT_W-1:0] dt;
	} mem_rsp_t;

endpackage

/* tb_mera_bus.sv */
module tb_mera_bus;
	timeunit 1ns;
	timeprecision 100ps;

	// longest wait in cycles for one handshake
	localparam int WAIT_LIMIT = 200;
	// longest wait for all answers of a phase
	localparam int DRAIN_LIMIT = 2000;
	// words shared by both channels
	localparam int POOL = 8;

	logic clk_sys;
	logic rst_n;

	// bit 0 is the cpu channel and bit 1 the i/o channel
	logic [1:0]                   req_valid;
	logic [1:0]                   req_ready;
	mera_pkg::bus_req_t [1:0]     req;
	logic [1:0]                   rsp_valid;
	logic [1:0]                   rsp_ready;
	mera_pkg::bus_rsp_t [1:0]     rsp;

	// random back-pressure on the answer side
	logic bp_on;

	// shadow of the present memory
	logic [mera_pkg::DT_W-1:0] shadow [mera_pkg::MEM_SEGMENTS][mera_pkg::MEM_SEG_WORDS];

	// expected answers in acceptance order per channel
	mera_pkg::bus_rsp_t exp_cpu [$];
	mera_pkg::bus_rsp_t exp_io [$];

	mera_bus i_dut (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.req_valid_cpu (req_valid[0]),
		.req_ready_cpu (req_ready[0]),
		.req_cpu       (req[0]),
		.rsp_valid_cpu (rsp_valid[0]),
		.rsp_ready_cpu (rsp_ready[0]),
		.rsp_cpu       (rsp[0]),
		.req_valid_io  (req_valid[1]),
		.req_ready_io  (req_ready[1]),
		.req_io        (req[1]),
		.rsp_valid_io  (rsp_valid[1]),
		.rsp_ready_io  (rsp_ready[1]),
		.rsp_io        (rsp[1])
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------

	// absent segment or word gives alarm and a write answers zero
	function automatic mera_pkg::bus_rsp_t expect_rsp(mera_pkg::bus_req_t r);
		mera_pkg::bus_rsp_t e;
		int                 seg;
		int                 word;
		logic [15:0]        old;
		seg      = int'(r.nb);
		word     = int'(r.ad);
		e.status = mera_pkg::st_alarm;
		e.dt     = '0;
		if (seg < mera_pkg::MEM_SEGMENTS && word < mera_pkg::MEM_SEG_WORDS) begin
			old      = shadow[seg][word];
			e.status = mera_pkg::st_ok;
			case (r.cmd)
				mera_pkg::cmd_w: begin
					shadow[seg][word] = r.dt;
				end
				mera_pkg::cmd_s: begin
					shadow[seg][word] = old | r.dt;
					e.dt              = old;
				end
				default: begin
					e.dt = old;
				end
			endcase
		end
		return e;
	endfunction

	function automatic mera_pkg::bus_req_t make_req(mera_pkg::bus_cmd_e cmd, int nb, int ad,
			logic [15:0] dt);
		mera_pkg::bus_req_t r;
		r.cmd = cmd;
		r.nb  = 4'(nb);
		r.ad  = 16'(ad);
		r.dt  = dt;
		return r;
	endfunction

	// pool words alternate between segments 0 and 1
	function automatic mera_pkg::bus_req_t pool_req(mera_pkg::bus_cmd_e cmd, int idx,
			logic [15:0] dt);
		return make_req(cmd, idx % 2, idx * 29 + 3, dt);
	endfunction

	function automatic int pending(int ch);
		return (ch == 0) ? exp_cpu.size() : exp_io.size();
	endfunction

	function automatic mera_pkg::bus_rsp_t pop_expect(int ch);
		mera_pkg::bus_rsp_t e;
		if (ch == 0) begin
			e = exp_cpu.pop_front();
		end else begin
			e = exp_io.pop_front();
		end
		return e;
	endfunction

	// ----------------------------------------
	// error reporting and checks
	// ----------------------------------------

	task automatic abort_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_error(string what);
		$display("ERROR at %0t ns: %s", $time, what);
		abort_run();
	endtask

	task automatic check_status(string name, mera_pkg::bus_status_e got,
			mera_pkg::bus_status_e exp);
		if (got !== exp) begin
			$display("FAIL %0t ns %s.status got %s expected %s", $time, name, got.name(),
				exp.name());
			abort_run();
		end
	endtask

	task automatic check_rsp(string name, mera_pkg::bus_rsp_t got, mera_pkg::bus_rsp_t exp);
		if (got !== exp) begin
			$display("FAIL %0t ns %s got status=%0d dt=%h expected status=%0d dt=%h", $time,
				name, got.status, got.dt, exp.status, exp.dt);
			abort_run();
		end
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------

	// expected answer is queued the cycle the channel takes the request
	task automatic send_req(int ch, mera_pkg::bus_req_t r);
		int n;
		n = 0;
		@(negedge clk_sys);
		req_valid[ch] = 1'b1;
		req[ch]       = r;
		while (!req_ready[ch]) begin
			@(negedge clk_sys);
			n++;
			if (n > WAIT_LIMIT) begin
				report_error("channel never accepted its request");
			end
		end
		if (ch == 0) begin
			exp_cpu.push_back(expect_rsp(r));
		end else begin
			exp_io.push_back(expect_rsp(r));
		end
		@(negedge clk_sys);
		req_valid[ch] = 1'b0;
	endtask

	task automatic send_random(int ch, int idx);
		mera_pkg::bus_req_t r;
		int                 gap;
		gap = int'($urandom_range(0, 3));
		r   = pool_req(mera_pkg::bus_cmd_e'(2'($urandom_range(0, 2))), idx, 16'($urandom));
		// now and then aim at a hole in the map
		if ($urandom_range(0, 7) == 0) begin
			if ($urandom_range(0, 1) == 0) begin
				r.nb = 4'd5;
			end else begin
				r.ad = 16'd300;
			end
		end
		repeat (gap) @(negedge clk_sys);
		send_req(ch, r);
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (pending(0) != 0 || pending(1) != 0) begin
			@(negedge clk_sys);
			n++;
			if (n > DRAIN_LIMIT) begin
				report_error("answers still missing at end of phase");
			end
		end
	endtask

	// ----------------------------------------
	// answer side ready, stability and compare
	// ----------------------------------------

	task automatic watch_answers(int ch);
		mera_pkg::bus_rsp_t held;
		mera_pkg::bus_rsp_t e;
		logic               stalled;
		string              name;
		name    = (ch == 0) ? "rsp_cpu" : "rsp_io";
		stalled = 1'b0;
		held    = '0;
		forever begin
			@(negedge clk_sys);
			// refused answer must still be offered unchanged
			if (stalled) begin
				if (!rsp_valid[ch]) begin
					report_error("answer withdrawn before it was taken");
				end
				check_rsp(name, rsp[ch], held);
			end
			if (rsp_valid[ch] && req_ready[ch]) begin
				report_error("channel ready for a request while holding an answer");
			end
			rsp_ready[ch] = bp_on ? ($urandom_range(0, 2) == 0) : 1'b1;
			if (rsp_valid[ch] && rsp_ready[ch]) begin
				if (pending(ch) == 0) begin
					report_error("answer arrived with no request outstanding");
				end
				e = pop_expect(ch);
				check_status(name, rsp[ch].status, e.status);
				check_rsp(name, rsp[ch], e);
				stalled = 1'b0;
			end else begin
				stalled = rsp_valid[ch];
				held    = rsp[ch];
			end
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial begin
		int i;
		int a;
		int b;
		void'($urandom(43004));
		rst_n     = 1'b0;
		req_valid = '0;
		req       = '0;
		rsp_ready = '0;
		bp_on     = 1'b0;
		repeat (8) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);
		if (req_ready !== 2'b11 || rsp_valid !== 2'b00) begin
			report_error("channels not idle after reset");
		end
		fork
			watch_answers(0);
			watch_answers(1);
		join_none

		// writes then reads on cpu over both segments
		for (i = 0; i < POOL; i++) begin
			send_req(0, pool_req(mera_pkg::cmd_w, i, 16'($urandom)));
		end
		for (i = 0; i < POOL; i++) begin
			send_req(0, pool_req(mera_pkg::cmd_r, i, 16'h0));
		end
		wait_drain();

		// set returns the old word and the OR stays in memory
		send_req(0, make_req(mera_pkg::cmd_w, 0, 10, 16'h0f0f));
		send_req(0, make_req(mera_pkg::cmd_s, 0, 10, 16'h3300));
		send_req(1, pool_req(mera_pkg::cmd_s, 3, 16'h8001));
		send_req(0, make_req(mera_pkg::cmd_r, 0, 10, 16'h0));
		wait_drain();
		send_req(0, pool_req(mera_pkg::cmd_r, 3, 16'h0));
		wait_drain();

		// holes in the map time out and later traffic still flows
		send_req(0, make_req(mera_pkg::cmd_r, 5, 3, 16'h0));
		send_req(1, make_req(mera_pkg::cmd_w, 0, 300, 16'hbeef));
		send_req(0, make_req(mera_pkg::cmd_s, 1, 300, 16'h00ff));
		send_req(1, pool_req(mera_pkg::cmd_r, 0, 16'h0));
		send_req(0, make_req(mera_pkg::cmd_r, 0, 10, 16'h0));
		wait_drain();

		// both channels at once on distinct words per round
		for (i = 0; i < 80; i++) begin
			a = int'($urandom_range(0, POOL - 1));
			b = int'($urandom_range(0, POOL - 1));
			if (b == a) begin
				b = (a + 1) % POOL;
			end
			fork
				send_random(0, a);
				send_random(1, b);
			join
			wait_drain();
		end

		// same traffic with answers throttled
		bp_on = 1'b1;
		for (i = 0; i < 40; i++) begin
			a = int'($urandom_range(0, POOL - 1));
			b = (a + 1 + int'($urandom_range(0, POOL - 2))) % POOL;
			fork
				send_random(0, a);
				send_random(1, b);
			join
			wait_drain();
		end
		bp_on = 1'b0;
		for (i = 0; i < POOL; i++) begin
			send_req(1, pool_req(mera_pkg::cmd_r, i, 16'h0));
		end
		wait_drain();

		$display("Test completed successfully");
		$finish;
	end

endmodule
